/* pooling_top.f */
src/pool_pkg.sv
src/pool_config.sv
src/pool_sequencer.sv
src/subword_max.sv
src/pool_datapath.sv
src/pooling_top.sv
testbench/pooling_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pooling testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f pooling_top.f --top-module pooling_tb -o pooling_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/pooling_sim | tee /dev/stderr | grep -q "All checks passed" \
  && exit 0 \
  || exit 1

/* src/pool_config.sv */
module pool_config
  import pool_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       busy,
  input  pool_mode_t mode,
  input  precision_t precision,
  input  count_t     row_words,
  input  count_t     out_words,
  output pool_mode_t cfg_mode,
  output precision_t cfg_precision,
  output count_t     cfg_row_words,
  output count_t     cfg_out_words
);

  logic accept;

  // starts during a running job are dropped
  assign accept = start && !busy;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      cfg_mode      <= pool_1d;
      cfg_precision <= prec_8;
      cfg_row_words <= '0;
      cfg_out_words <= '0;
    end
    else if (accept)
    begin
      cfg_mode      <= mode;
      cfg_precision <= precision;
      cfg_row_words <= row_words;
      cfg_out_words <= out_words;
    end
  end

  // an empty job would wrap the output counter
  assert property (@(posedge clk) disable iff (!reset)
    accept |-> (out_words != '0))
  else
    $error("pool_config: job accepted with out_words of zero");

endmodule

/* src/pool_datapath.sv */
module pool_datapath
  import pool_pkg::*;
#(
  parameter int n_lanes = default_lanes
)
(
  input  logic       clk,
  input  logic       reset,
  input  precision_t cfg_precision,
  input  lane_t      read_word [n_lanes],
  input  logic       capture,
  input  logic       reduce_1d,
  input  logic       reduce_2d,
  input  logic [1:0] step,
  input  logic       clear,
  output lane_t      out_word [n_lanes]
);

  localparam int n_1d = n_lanes / 4;
  localparam int n_2d = n_lanes / 2;

  lane_t hold   [n_lanes];
  lane_t result [n_lanes];
  lane_t max_1d [n_1d];
  lane_t max_2d [n_2d];

  // upper row of the window, or the whole word in 1D
  always_ff @(posedge clk)
  begin
    if (capture)
      hold <= read_word;
  end

  // 1D max over four adjacent lanes of the held word
  for (genvar g = 0; g < n_1d; g++)
  begin : gen_1d
    lane_t win [4];

    always_comb
    begin
      for (int k = 0; k < 4; k++)
        win[k] = hold[4*g + k];
    end

    subword_max #(
      .n_in(4)
    ) u_max (
      .precision(cfg_precision),
      .vals     (win),
      .max_val  (max_1d[g])
    );
  end

  // 2D max over a lane pair in the held row and the same pair one row below
  for (genvar g = 0; g < n_2d; g++)
  begin : gen_2d
    lane_t win [4];

    always_comb
    begin
      win[0] = hold[2*g];
      win[1] = hold[2*g + 1];
      win[2] = read_word[2*g];
      win[3] = read_word[2*g + 1];
    end

    subword_max #(
      .n_in(4)
    ) u_max (
      .precision(cfg_precision),
      .vals     (win),
      .max_val  (max_2d[g])
    );
  end

  // each step fills one slot of the output word
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < n_lanes; i++)
        result[i] <= '0;
    end
    else if (clear)
    begin
      for (int i = 0; i < n_lanes; i++)
        result[i] <= '0;
    end
    else if (reduce_1d)
    begin
      for (int j = 0; j < n_1d; j++)
        result[n_1d*int'(step) + j] <= max_1d[j];
    end
    else if (reduce_2d)
    begin
      for (int j = 0; j < n_2d; j++)
        result[n_2d*int'(step[0]) + j] <= max_2d[j];
    end
  end

  assign out_word = result;

endmodule

/* src/pool_pkg.sv */
package pool_pkg;

  // bits per lane as the 4-bit and 2-bit subword split needs
  localparam int lane_width = 8;

  // activation memory address width
  localparam int addr_width = 16;

  // lanes per word in multiples of 4
  localparam int default_lanes = 8;

  typedef enum logic {
    pool_1d = 1'b0,
    pool_2d = 1'b1
  } pool_mode_t;

  // code 3 is illegal
  typedef enum logic [1:0] {
    prec_8 = 2'd0,
    prec_4 = 2'd1,
    prec_2 = 2'd2
  } precision_t;

  typedef logic signed [lane_width-1:0] lane_t;

  // row_words and out_words
  typedef logic [15:0] count_t;

endpackage

/* src/pool_sequencer.sv */
module pool_sequencer
  import pool_pkg::*;
#(
  parameter int addr_bits = addr_width
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  pool_mode_t           cfg_mode,
  input  count_t               cfg_row_words,
  input  count_t               cfg_out_words,
  output logic                 busy,
  output logic                 rd_en,
  output logic [addr_bits-1:0] rd_addr,
  output logic                 capture,
  output logic                 reduce_1d,
  output logic                 reduce_2d,
  output logic [1:0]           step,
  output logic                 clear,
  output logic                 wr_en,
  output logic [addr_bits-1:0] wr_addr,
  output logic                 done
);

  typedef enum logic [2:0] {
    st_idle,
    st_issue,
    st_capture,
    st_reduce,
    st_write
  } state_t;

  state_t               state;
  logic [addr_bits-1:0] base;
  count_t               col;
  count_t               out_cnt;
  logic                 last_step;
  logic                 last_col;
  logic                 last_word;
  logic                 skip_row;

  // 4 slots per word in 1D, 2 in 2D
  assign last_step = (cfg_mode == pool_1d) ? (step == 2'd3) : (step == 2'd1);
  assign last_col  = (col == cfg_row_words - 16'd1);
  assign last_word = (out_cnt == cfg_out_words - 16'd1);

  // 2D consumes two input rows, so jump past the lower one
  assign skip_row = (cfg_mode == pool_2d) && last_col;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state   <= st_idle;
      base    <= '0;
      col     <= '0;
      step    <= '0;
      out_cnt <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          base    <= '0;
          col     <= '0;
          step    <= '0;
          out_cnt <= '0;
          if (start)
            state <= st_issue;
        end
        st_issue:
          state <= st_capture;
        st_capture:
          state <= st_reduce;
        st_reduce:
        begin
          if (skip_row)
            base <= base + addr_bits'(cfg_row_words) + 1'b1;
          else
            base <= base + 1'b1;
          if (cfg_mode == pool_2d)
            col <= last_col ? '0 : col + 16'd1;
          if (last_step)
          begin
            step  <= '0;
            state <= st_write;
          end
          else
          begin
            step  <= step + 2'd1;
            state <= st_issue;
          end
        end
        st_write:
        begin
          if (last_word)
          begin
            state <= st_idle;
          end
          else
          begin
            out_cnt <= out_cnt + 16'd1;
            state   <= st_issue;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  assign busy  = (state != st_idle);
  assign clear = (state == st_idle) && start;

  // second read in capture fetches the row below
  assign rd_en   = (state == st_issue) || ((state == st_capture) && (cfg_mode == pool_2d));
  assign rd_addr = (state == st_capture) ? base + addr_bits'(cfg_row_words) : base;

  assign capture   = (state == st_capture);
  assign reduce_1d = (state == st_reduce) && (cfg_mode == pool_1d);
  assign reduce_2d = (state == st_reduce) && (cfg_mode == pool_2d);

  assign wr_en   = (state == st_write);
  assign wr_addr = addr_bits'(out_cnt);
  assign done    = wr_en && last_word;

  assert property (@(posedge clk) disable iff (!reset) !(rd_en && wr_en))
  else
    $error("pool_sequencer: read and write issued in the same cycle");

  assert property (@(posedge clk) disable iff (!reset) done |-> wr_en)
  else
    $error("pool_sequencer: done without a write");

endmodule

/* src/pooling_top.sv */
module pooling_top
  import pool_pkg::*;
#(
  parameter int n_lanes   = default_lanes,
  parameter int addr_bits = addr_width
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  pool_mode_t           mode,
  input  precision_t           precision,
  input  count_t               row_words,
  input  count_t               out_words,
  input  lane_t                read_word [n_lanes],
  output logic                 rd_en,
  output logic [addr_bits-1:0] rd_addr,
  output logic                 wr_en,
  output logic [addr_bits-1:0] wr_addr,
  output lane_t                out_word [n_lanes],
  output logic                 done
);

  pool_mode_t cfg_mode;
  precision_t cfg_precision;
  count_t     cfg_row_words;
  count_t     cfg_out_words;
  logic       busy;
  logic       capture;
  logic       reduce_1d;
  logic       reduce_2d;
  logic [1:0] step;
  logic       clear;

  pool_config u_config (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .busy         (busy),
    .mode         (mode),
    .precision    (precision),
    .row_words    (row_words),
    .out_words    (out_words),
    .cfg_mode     (cfg_mode),
    .cfg_precision(cfg_precision),
    .cfg_row_words(cfg_row_words),
    .cfg_out_words(cfg_out_words)
  );

  pool_sequencer #(
    .addr_bits(addr_bits)
  ) u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .cfg_mode     (cfg_mode),
    .cfg_row_words(cfg_row_words),
    .cfg_out_words(cfg_out_words),
    .busy         (busy),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .capture      (capture),
    .reduce_1d    (reduce_1d),
    .reduce_2d    (reduce_2d),
    .step         (step),
    .clear        (clear),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .done         (done)
  );

  pool_datapath #(
    .n_lanes(n_lanes)
  ) u_datapath (
    .clk          (clk),
    .reset        (reset),
    .cfg_precision(cfg_precision),
    .read_word    (read_word),
    .capture      (capture),
    .reduce_1d    (reduce_1d),
    .reduce_2d    (reduce_2d),
    .step         (step),
    .clear        (clear),
    .out_word     (out_word)
  );

endmodule

/* src/subword_max.sv */
module subword_max
  import pool_pkg::*;
#(
  parameter int n_in = 4
)
(
  input  precision_t precision,
  input  lane_t      vals [n_in],
  output lane_t      max_val
);

  localparam int half    = lane_width / 2;
  localparam int quarter = lane_width / 4;

  lane_t                    m8;
  logic signed [half-1:0]    m4 [2];
  logic signed [quarter-1:0] m2 [4];

  // every subword position keeps its own running max
  always_comb
  begin
    m8 = vals[0];
    for (int h = 0; h < 2; h++)
      m4[h] = vals[0][half*h +: half];
    for (int q = 0; q < 4; q++)
      m2[q] = vals[0][quarter*q +: quarter];
    for (int i = 1; i < n_in; i++)
    begin
      if (vals[i] > m8)
        m8 = vals[i];
      for (int h = 0; h < 2; h++)
      begin
        if ($signed(vals[i][half*h +: half]) > m4[h])
          m4[h] = vals[i][half*h +: half];
      end
      for (int q = 0; q < 4; q++)
      begin
        if ($signed(vals[i][quarter*q +: quarter]) > m2[q])
          m2[q] = vals[i][quarter*q +: quarter];
      end
    end
  end

  // repack in the original bit positions
  always_comb
  begin
    case (precision)
      prec_4:  max_val = {m4[1], m4[0]};
      prec_2:  max_val = {m2[3], m2[2], m2[1], m2[0]};
      default: max_val = m8;
    endcase
  end

  always_comb
  begin
    assert ($isunknown(precision) || precision != 2'd3)
    else
      $error("subword_max: precision code 3 is illegal");
  end

endmodule

/* testbench/pool_stimulus.txt */
# job <mode> <precision> <row_words> <out_words> <mem_words> <stray_start>
# then mem_words memory words and out_words expected words, hex, lane 7 first
job 0 0 4 2 8 0
8180FDFEFF7F8001
0201FF0005302010
413FC04080808080
06050505C0D0E0F0
00007E0000000005
FFFFFFFFFFFFFFFF
0807060504030201
636261609F9E9D9C
06F041800230FE7F
639F0804FFFF7E05
job 1 0 2 2 8 0
13121110FF800201
404040400000007F
F3F2F1F0FE810003
0000410000000000
8080808080808085
0807060504030201
8080808080808080
0000000000000000
4041007F1311FF03
0806040280808085
job 0 1 4 1 4 0
E9F89E8F8507231F
1111111100000F70
7008807F88888888
00004CC400001001
441170881170FF27
# mem_words of 0 keeps the previous memory image
job 0 2 4 1 0 0
441140881140DD15
job 1 2 1 1 4 1
00010000C0FF431C
00000000FFFFB1AA
0000007F80808080
0000000000000000
004000000100C051
job 1 1 1 1 0 0
007000000100F043

/* testbench/pooling_tb.sv */
module pooling_tb
  import pool_pkg::*;
;

  localparam int n_lanes   = 8;
  localparam int addr_bits = 16;
  localparam int mem_depth = 256;
  localparam int max_out   = 16;
  localparam int job_limit = 2000;

  logic                 clk;
  logic                 reset;
  logic                 start;
  pool_mode_t           mode;
  precision_t           precision;
  count_t               row_words;
  count_t               out_words;
  lane_t                read_word [n_lanes];
  logic                 rd_en;
  logic [addr_bits-1:0] rd_addr;
  logic                 wr_en;
  logic [addr_bits-1:0] wr_addr;
  lane_t                out_word [n_lanes];
  logic                 done;

  logic [63:0] mem [mem_depth];
  logic [63:0] expected [max_out];
  logic [63:0] got;
  int          cycle;
  int          start_cycle;
  int          exp_cycle;
  int          n_expected;
  int          writes_seen;
  int          reads_seen;
  int          fd;
  bit          checking;
  pool_mode_t  job_mode;

  pooling_top #(
    .n_lanes  (n_lanes),
    .addr_bits(addr_bits)
  ) dut (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .mode     (mode),
    .precision(precision),
    .row_words(row_words),
    .out_words(out_words),
    .read_word(read_word),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .out_word (out_word),
    .done     (done)
  );

  initial
    clk = 1'b0;

  always #5 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // memory answers one cycle after rd_en
  always @(posedge clk)
  begin
    if (rd_en)
    begin
      assert (int'(rd_addr) < mem_depth)
      else
        report_failure($sformatf("read address %0d is outside the memory model", rd_addr));
      for (int i = 0; i < n_lanes; i++)
        read_word[i] <= mem[rd_addr[7:0]][8*i +: 8];
    end
  end

  // read and write monitor on the falling edge
  always @(negedge clk)
  begin
    if (checking && reset)
    begin
      if (rd_en)
        reads_seen = reads_seen + 1;
      if (wr_en)
      begin
        for (int i = 0; i < n_lanes; i++)
          got[8*i +: 8] = out_word[i];
        assert (writes_seen < n_expected)
        else
          report_failure("a write arrived after the last output word of the job");
        exp_cycle = start_cycle - 1 + ((job_mode == pool_1d) ? 13 : 7) * (writes_seen + 1);
        assert (cycle == exp_cycle)
        else
          report_failure($sformatf("FAIL t=%0t wr_en cycle expected %0d got %0d",
                                   $time, exp_cycle - start_cycle, cycle - start_cycle));
        assert (wr_addr == addr_bits'(writes_seen))
        else
          report_failure($sformatf("FAIL t=%0t wr_addr expected %0d got %0d",
                                   $time, writes_seen, wr_addr));
        assert (got == expected[writes_seen])
        else
          report_failure($sformatf("FAIL t=%0t out_word expected %h got %h",
                                   $time, expected[writes_seen], got));
        assert (done == (writes_seen == n_expected - 1))
        else
          report_failure($sformatf("FAIL t=%0t done expected %0b got %0b",
                                   $time, writes_seen == n_expected - 1, done));
        writes_seen = writes_seen + 1;
      end
      else
      begin
        assert (!done)
        else
          report_failure("done pulsed in a cycle without a write");
      end
    end
  end

  // next line that is neither blank nor a comment
  task automatic read_line(output string line, output bit ok);
    string raw;
    int    r;
    ok   = 1'b0;
    line = "";
    while (!ok && !$feof(fd))
    begin
      raw = "";
      r = $fgets(raw, fd);
      if (r != 0 && raw.len() > 0 && raw[0] != "#" && raw[0] != "\n")
      begin
        line = raw;
        ok   = 1'b1;
      end
    end
  endtask

  initial
  begin : driver
    string       line;
    string       tag;
    bit          ok;
    int          n;
    int          f_mode;
    int          f_prec;
    int          f_row;
    int          f_out;
    int          f_mem;
    int          f_stray;
    int          jobs_run;
    int          waited;
    logic [63:0] word;

    reset       = 1'b0;
    start       = 1'b0;
    mode        = pool_1d;
    precision   = prec_8;
    row_words   = '0;
    out_words   = '0;
    cycle       <= 0;
    checking    = 1'b0;
    writes_seen = 0;
    reads_seen  = 0;
    n_expected  = 0;
    start_cycle = 0;
    job_mode    = pool_1d;
    jobs_run    = 0;
    for (int i = 0; i < n_lanes; i++)
      read_word[i] <= '0;
    for (int a = 0; a < mem_depth; a++)
      mem[a] = {8{8'(a) ^ 8'h5a}};

    fd = $fopen("testbench/pool_stimulus.txt", "r");
    if (fd == 0)
      report_failure("the stimulus file testbench/pool_stimulus.txt could not be opened");

    repeat (2) @(posedge clk);
    #1 reset = 1'b1;
    @(negedge clk);
    assert (!rd_en && !wr_en && !done)
    else
      report_failure("rd_en, wr_en or done is high right after reset");

    read_line(line, ok);
    while (ok)
    begin
      n = $sscanf(line, "%s %d %d %d %d %d %d", tag, f_mode, f_prec, f_row, f_out,
                  f_mem, f_stray);
      if (n != 7 || tag != "job")
        report_failure($sformatf("malformed job header in stimulus file: %s", line));
      if (f_out < 1 || f_out > max_out || f_mem > mem_depth || f_mode > 1 || f_prec > 2)
        report_failure($sformatf("job fields out of range in stimulus file: %s", line));

      if (f_mem > 0)
      begin
        for (int a = 0; a < mem_depth; a++)
          mem[a] = {8{8'(a) ^ 8'h5a}};
      end
      for (int a = 0; a < f_mem; a++)
      begin
        read_line(line, ok);
        if (!ok || $sscanf(line, "%h", word) != 1)
          report_failure("stimulus file ended or broke inside a memory image");
        mem[a] = word;
      end
      for (int k = 0; k < f_out; k++)
      begin
        read_line(line, ok);
        if (!ok || $sscanf(line, "%h", word) != 1)
          report_failure("stimulus file ended or broke inside the expected words");
        expected[k] = word;
      end

      @(posedge clk);
      #1;
      start       = 1'b1;
      mode        = pool_mode_t'(f_mode);
      precision   = precision_t'(f_prec);
      row_words   = count_t'(f_row);
      out_words   = count_t'(f_out);
      job_mode    = pool_mode_t'(f_mode);
      n_expected  = f_out;
      writes_seen = 0;
      reads_seen  = 0;
      start_cycle = cycle + 1;
      checking    = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;

      // a second start mid-job with different fields must be dropped
      if (f_stray != 0)
      begin
        repeat (3) @(posedge clk);
        #1;
        start     = 1'b1;
        mode      = (job_mode == pool_1d) ? pool_2d : pool_1d;
        precision = prec_8;
        out_words = 16'd5;
        @(posedge clk);
        #1 start = 1'b0;
      end

      waited = 0;
      while (writes_seen < n_expected && waited < job_limit)
      begin
        @(posedge clk);
        waited = waited + 1;
      end
      assert (writes_seen == n_expected)
      else
        report_failure($sformatf("timeout: job %0d wrote %0d of %0d words",
                                 jobs_run, writes_seen, n_expected));

      // extra writes after done are caught by the monitor
      repeat (20) @(posedge clk);

      // one read per 1D step, two per 2D step, four in either mode per word
      assert (reads_seen == 4 * n_expected)
      else
        report_failure($sformatf("FAIL t=%0t rd_en count expected %0d got %0d",
                                 $time, 4 * n_expected, reads_seen));
      jobs_run = jobs_run + 1;
      read_line(line, ok);
    end
    $fclose(fd);

    if (jobs_run > 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      report_failure("the stimulus file holds no jobs");
    end
  end

endmodule
